// File: rtl/fetch_defs.svh
/*
  Fetch front end sizing
  Widths, memory depth, predictor size and the reset vector
*/
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Datapath width for PC and instruction word
`define XLEN 16

// Instruction memory geometry
`define IMEM_DEPTH 256
`define IMEM_AW 8

// Branch target buffer geometry, index is the low PC bits
`define BP_ENTRIES 16
`define BP_IDX_W 4

`define RESET_PC 16'h0000 // First fetch address after reset

`endif

// File: rtl/fetch_pkg.sv
/*
  Shared types of the fetch front end
  APB request and response, prediction, branch resolution, IF/ID packet
*/
`include "fetch_defs.svh"

package fetch_pkg;

  // APB master side signals
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [15:0]       paddr;  // Word address
    logic [15:0]       pwdata;
  } apb_req_t;

  // APB slave side signals
  typedef struct packed {
    logic              pready;
    logic [15:0]       prdata;
    logic              pslverr; // Address out of range
  } apb_rsp_t;

  typedef struct packed {
    logic              taken;  // Predicted taken
    logic [`XLEN-1:0]  target; // Predicted target
  } prediction_t;

  // Resolution from a later stage, single cycle pulse
  typedef struct packed {
    logic                 valid;
    logic                 branch;      // Control flow instr, trains BTB
    logic [`BP_IDX_W-1:0] index;       // BTB entry to train
    logic                 taken;
    logic [`XLEN-1:0]     target;
    logic                 mispredict;  // Redirect and flush
    logic [`XLEN-1:0]     redirect_pc;
  } resolve_t;

  // IF/ID payload
  typedef struct packed {
    logic [`BP_IDX_W-1:0] pc_low;          // Low PC bits for decode
    logic [`XLEN-1:0]     pc_next;
    logic [`XLEN-1:0]     inst;
    logic                 predicted_taken;
  } fetch_packet_t;

endpackage

// File: rtl/inst_mem.sv
/*
  Instruction memory
  APB slave for loading and read-back, zero wait states,
  plus an asynchronous read port for instruction fetch
*/
`include "fetch_defs.svh"

module inst_mem (
  input  logic                clk,
  input  logic                rst,
  input  fetch_pkg::apb_req_t apb_req, // From the loader
  output fetch_pkg::apb_rsp_t apb_rsp,
  input  logic [`XLEN-1:0]    pc,      // Fetch address
  output logic [`XLEN-1:0]    inst     // Word at pc
);

  logic [`XLEN-1:0] mem [`IMEM_DEPTH]; // Program storage, no reset

  logic in_range;
  logic setup_phase;
  logic access_phase;

  assign in_range     = apb_req.paddr < 16'(`IMEM_DEPTH);
  assign setup_phase  = apb_req.psel & ~apb_req.penable;
  assign access_phase = apb_req.psel & apb_req.penable;

  ////////////////////////////////
  // APB slave
  ////////////////////////////////
  // Response is prepared during setup so it is steady in the access phase
  always_ff @(posedge clk) begin
    if (rst) begin
      apb_rsp <= '0;
    end else begin
      apb_rsp.pready  <= setup_phase;             // High for exactly one access phase
      apb_rsp.pslverr <= setup_phase & ~in_range;
      if (setup_phase && !apb_req.pwrite && in_range)
        apb_rsp.prdata <= mem[apb_req.paddr[`IMEM_AW-1:0]];
      else
        apb_rsp.prdata <= '0;                     // Writes and bad reads return zero
    end
  end

  // Write commits at the edge ending the access phase
  always_ff @(posedge clk) begin
    if (access_phase && apb_req.pwrite && in_range)
      mem[apb_req.paddr[`IMEM_AW-1:0]] <= apb_req.pwdata;
  end

  ////////////////////////////////
  // Fetch port
  ////////////////////////////////
  assign inst = mem[pc[`IMEM_AW-1:0]]; // PC wraps modulo depth

endmodule

// File: rtl/branch_predictor.sv
/*
  Branch predictor
  Direct mapped BTB with 2-bit saturating counters,
  looked up by fetch PC, trained by branch resolutions
*/
`include "fetch_defs.svh"

module branch_predictor (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`XLEN-1:0]       pc,         // Fetch PC
  input  fetch_pkg::resolve_t    resolve,    // Training input
  output fetch_pkg::prediction_t prediction
);

  // Per entry state
  logic             valid  [`BP_ENTRIES];
  logic [1:0]       ctr    [`BP_ENTRIES]; // 00 strong NT .. 11 strong T
  logic [`XLEN-1:0] target [`BP_ENTRIES]; // No reset, gated by valid

  logic [`BP_IDX_W-1:0] lookup_idx;
  logic                 train;
  logic [1:0]           ctr_cur;
  logic [1:0]           ctr_upd;

  ////////////////////////////////
  // Lookup
  ////////////////////////////////
  assign lookup_idx = pc[`BP_IDX_W-1:0];

  // Taken only on a valid entry leaning taken
  assign prediction.taken  = valid[lookup_idx] & ctr[lookup_idx][1];
  assign prediction.target = target[lookup_idx];

  ////////////////////////////////
  // Training
  ////////////////////////////////
  assign train   = resolve.valid & resolve.branch;
  assign ctr_cur = ctr[resolve.index];

  // Saturating counter step
  always_comb begin
    ctr_upd = ctr_cur;
    if (resolve.taken) begin
      if (ctr_cur != 2'b11)
        ctr_upd = ctr_cur + 2'b01;
    end else if (ctr_cur != 2'b00) begin
      ctr_upd = ctr_cur - 2'b01;
    end
  end

  // Control state, cleared to invalid and weakly not taken
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `BP_ENTRIES; i++) begin
        valid[i] <= 1'b0;
        ctr[i]   <= 2'b01;
      end
    end else if (train) begin
      valid[resolve.index] <= 1'b1;
      ctr[resolve.index]   <= ctr_upd;
    end
  end

  // Target only learned from taken branches
  always_ff @(posedge clk) begin
    if (train && resolve.taken)
      target[resolve.index] <= resolve.target;
  end

endmodule

// File: rtl/next_pc_select.sv
/*
  Next PC selection
  Owns the PC register; redirect beats prediction beats PC + 1
*/
`include "fetch_defs.svh"

module next_pc_select (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,      // Hold fetch
  input  fetch_pkg::resolve_t    resolve,    // Redirect source
  input  fetch_pkg::prediction_t prediction, // BTB result for pc
  output logic [`XLEN-1:0]       pc,
  output logic [`XLEN-1:0]       pc_next     // Also recorded in IF/ID
);

  logic redirect;

  ////////////////////////////////
  // Next address
  ////////////////////////////////
  // Predicted path, or fall through
  assign pc_next = prediction.taken ? prediction.target : pc + `XLEN'(1);

  // Mispredict redirect wins even while stalled
  assign redirect = resolve.valid & resolve.mispredict;

  ////////////////////////////////
  // PC register
  ////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst)
      pc <= `RESET_PC;
    else if (redirect)
      pc <= resolve.redirect_pc; // Restart at the correct path
    else if (!stall)
      pc <= pc_next;
    // Stall without redirect holds pc
  end

endmodule

// File: rtl/if_id_pipe_reg.sv
/*
  IF/ID pipeline register
  Stall holds the packet, flush clears the instruction and prediction bit
*/
module if_id_pipe_reg (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stall,     // Freeze the packet
  input  logic                     flush,     // Kill the fetched instruction
  input  fetch_pkg::fetch_packet_t fetch_in,
  output fetch_pkg::fetch_packet_t fetch_out
);

  logic load;  // Capture new packet
  logic clear; // Clear the payload fields

  assign load  = ~stall;
  assign clear = flush | rst;

  // Address fields, only rst clears them
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_out.pc_low  <= '0;
      fetch_out.pc_next <= '0;
    end else if (load) begin
      fetch_out.pc_low  <= fetch_in.pc_low;
      fetch_out.pc_next <= fetch_in.pc_next;
    end
  end

  // Instruction and prediction, flush has priority over stall
  always_ff @(posedge clk) begin
    if (clear) begin
      fetch_out.inst            <= '0; // Becomes a NOP
      fetch_out.predicted_taken <= 1'b0;
    end else if (load) begin
      fetch_out.inst            <= fetch_in.inst;
      fetch_out.predicted_taken <= fetch_in.predicted_taken;
    end
  end

endmodule

// File: rtl/fetch_frontend.sv
/*
  Instruction fetch front end
  PC, instruction memory, branch predictor and the IF/ID register
*/
`include "fetch_defs.svh"

module fetch_frontend (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stall,   // From the hazard logic
  input  fetch_pkg::resolve_t      resolve, // From a later stage
  input  fetch_pkg::apb_req_t      apb_req, // Program loader
  output fetch_pkg::apb_rsp_t      apb_rsp,
  output fetch_pkg::fetch_packet_t if_id    // To decode
);

  logic [`XLEN-1:0]         pc;
  logic [`XLEN-1:0]         pc_next;
  logic [`XLEN-1:0]         inst;
  logic                     flush;
  fetch_pkg::prediction_t   prediction;
  fetch_pkg::fetch_packet_t fetch_pkt;

  ////////////////////////////////
  // Fetch stage
  ////////////////////////////////
  next_pc_select u_next_pc_select (
    .clk        (clk),
    .rst        (rst),
    .stall      (stall),
    .resolve    (resolve),
    .prediction (prediction),
    .pc         (pc),
    .pc_next    (pc_next)
  );

  // Memory and BTB see the same PC in parallel
  inst_mem u_inst_mem (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .pc      (pc),
    .inst    (inst)
  );

  branch_predictor u_branch_predictor (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .resolve    (resolve),
    .prediction (prediction)
  );

  ////////////////////////////////
  // IF/ID
  ////////////////////////////////
  assign fetch_pkt.pc_low          = pc[`BP_IDX_W-1:0];
  assign fetch_pkt.pc_next         = pc_next;
  assign fetch_pkt.inst            = inst;
  assign fetch_pkt.predicted_taken = prediction.taken;

  assign flush = resolve.valid & resolve.mispredict; // Wrong path fetched

  if_id_pipe_reg u_if_id_pipe_reg (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .flush     (flush),
    .fetch_in  (fetch_pkt),
    .fetch_out (if_id)
  );

endmodule

// File: testbench/tb_clock.sv
/*
  Testbench clock and power-on reset
  8 ns clock, reset high for the first two rising edges
*/
module tb_clock #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk) rst = 1'b0; // Release away from the sampling edge
  end

endmodule

// File: testbench/tb_fetch_frontend.sv
/*
  Testbench of the fetch front end
  APB load, sequential fetch, stall, mispredict redirect and BTB training,
  checked by concurrent assertions against a reference model
*/
`include "fetch_defs.svh"

module tb_fetch_frontend;
  timeunit 1ns;
  timeprecision 100ps;

  // Cycle budget per test for the watchdog
  localparam int LOAD_CYC  = 4 * `IMEM_DEPTH + 24;
  localparam int SEQ_CYC   = 48;
  localparam int STALL_CYC = 68;
  localparam int MISP_CYC  = 8 * 6 + 8;
  localparam int TRAIN_CYC = 100;
  localparam int WDOG_CYC  = (LOAD_CYC + SEQ_CYC + STALL_CYC + MISP_CYC + TRAIN_CYC) * 6 / 5;

  logic clk, por_rst, soft_rst, rst, stall;
  fetch_pkg::resolve_t      resolve;
  fetch_pkg::apb_req_t      apb_req;
  fetch_pkg::apb_rsp_t      apb_rsp;
  fetch_pkg::fetch_packet_t if_id;

  // Reference model state
  logic [`XLEN-1:0]         ref_mem [`IMEM_DEPTH];
  logic [`XLEN-1:0]         m_pc, m_nxt;
  logic [`BP_ENTRIES-1:0]   m_valid;
  logic [1:0]               m_ctr [`BP_ENTRIES];
  logic [`XLEN-1:0]         m_tgt [`BP_ENTRIES];
  logic                     m_pred, redirect, fetch_check, exp_slverr;
  logic [15:0]              exp_rdata;
  fetch_pkg::fetch_packet_t exp_if_id;
  int err_count, tests_passed, tests_failed, errs_start;

  tb_clock u_clock (.clk(clk), .rst(por_rst));

  assign rst = por_rst | soft_rst;

  fetch_frontend u_dut (
    .clk(clk), .rst(rst), .stall(stall), .resolve(resolve),
    .apb_req(apb_req), .apb_rsp(apb_rsp), .if_id(if_id)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////
  assign m_pred   = m_valid[m_pc[`BP_IDX_W-1:0]] & m_ctr[m_pc[`BP_IDX_W-1:0]][1];
  assign m_nxt    = m_pred ? m_tgt[m_pc[`BP_IDX_W-1:0]] : m_pc + 16'd1;
  assign redirect = resolve.valid & resolve.mispredict;

  always @(posedge clk) begin
    if (apb_req.psel && apb_req.penable && apb_req.pwrite && apb_req.paddr < `IMEM_DEPTH)
      ref_mem[apb_req.paddr[`IMEM_AW-1:0]] <= apb_req.pwdata; // Contents survive reset
  end

  always @(posedge clk) begin
    if (rst) begin
      m_pc      <= `RESET_PC;
      exp_if_id <= '0;
      m_valid   <= '0;
      for (int i = 0; i < `BP_ENTRIES; i++) m_ctr[i] <= 2'b01; // Weakly not taken
    end else begin
      if (!stall) begin
        exp_if_id.pc_low  <= m_pc[`BP_IDX_W-1:0];
        exp_if_id.pc_next <= m_nxt;
      end
      if (redirect) begin
        exp_if_id.inst            <= '0; // Wrong path killed
        exp_if_id.predicted_taken <= 1'b0;
      end else if (!stall) begin
        exp_if_id.inst            <= ref_mem[m_pc[`IMEM_AW-1:0]];
        exp_if_id.predicted_taken <= m_pred;
      end
      if (redirect) m_pc <= resolve.redirect_pc;
      else if (!stall) m_pc <= m_nxt;
      if (resolve.valid && resolve.branch) begin
        m_valid[resolve.index] <= 1'b1;
        if (resolve.taken) m_tgt[resolve.index] <= resolve.target;
        if (resolve.taken && m_ctr[resolve.index] != 2'b11)
          m_ctr[resolve.index] <= m_ctr[resolve.index] + 2'b01;
        else if (!resolve.taken && m_ctr[resolve.index] != 2'b00)
          m_ctr[resolve.index] <= m_ctr[resolve.index] - 2'b01;
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  a_apb_ready : assert property (@(posedge clk) disable iff (rst)
    (apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
    else begin
      err_count++;
      $display("CHECK FAILED t=%0t pready expected 1 actual %b", $time, $sampled(apb_rsp.pready));
    end

  a_apb_rdata : assert property (@(posedge clk) disable iff (rst)
    (apb_req.psel && apb_req.penable && !apb_req.pwrite) |-> apb_rsp.prdata == exp_rdata)
    else begin
      err_count++;
      $display("CHECK FAILED t=%0t prdata expected %h actual %h", $time,
               $sampled(exp_rdata), $sampled(apb_rsp.prdata));
    end

  a_apb_slverr : assert property (@(posedge clk) disable iff (rst)
    (apb_req.psel && apb_req.penable) |-> apb_rsp.pslverr == exp_slverr)
    else begin
      err_count++;
      $display("CHECK FAILED t=%0t pslverr expected %b actual %b", $time,
               $sampled(exp_slverr), $sampled(apb_rsp.pslverr));
    end

  // Whole packet against the model in every fetch test
  a_if_id_model : assert property (@(posedge clk) disable iff (rst)
    fetch_check |-> if_id == exp_if_id)
    else begin
      err_count++;
      $display("CHECK FAILED t=%0t if_id expected %h actual %h", $time,
               $sampled(exp_if_id), $sampled(if_id));
    end

  a_stall_hold : assert property (@(posedge clk) disable iff (rst)
    (stall && !redirect) |=> if_id == $past(if_id))
    else begin
      err_count++;
      $display("CHECK FAILED t=%0t if_id expected %h actual %h", $time,
               $past(if_id), $sampled(if_id));
    end

  a_flush_clear : assert property (@(posedge clk) disable iff (rst)
    redirect |=> (if_id.inst == '0 && !if_id.predicted_taken))
    else begin
      err_count++;
      $display("CHECK FAILED t=%0t if_id.inst/predicted_taken expected 0000/0 actual %h/%b",
               $time, $sampled(if_id.inst), $sampled(if_id.predicted_taken));
    end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  // One zero wait state transfer with setup then access
  task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [15:0] data);
    @(negedge clk);
    apb_req    = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
    exp_slverr = addr >= `IMEM_DEPTH;
    exp_rdata  = (addr < `IMEM_DEPTH) ? ref_mem[addr[`IMEM_AW-1:0]] : 16'h0000;
    @(negedge clk);
    apb_req.penable = 1'b1;
  endtask

  task automatic report_test(input string name);
    repeat (2) @(negedge clk); // Let pending implications finish
    if (err_count == errs_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d check(s) failed", name, err_count - errs_start);
    end
    errs_start = err_count;
  endtask

  initial begin
    repeat (WDOG_CYC) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", WDOG_CYC);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    logic [3:0]  idx;
    logic [15:0] tgt;
    void'($urandom(67924));
    {soft_rst, stall, fetch_check, exp_slverr} = '0;
    {resolve, apb_req, exp_rdata} = '0;
    {err_count, tests_passed, tests_failed, errs_start} = '0;
    @(negedge clk);
    while (por_rst) @(negedge clk);

    for (int a = 0; a < `IMEM_DEPTH; a++) apb_xfer(1'b1, 16'(a), 16'($urandom));
    for (int a = 0; a < `IMEM_DEPTH; a++) apb_xfer(1'b0, 16'(a), 16'h0000);
    apb_xfer(1'b1, 16'd300, 16'($urandom)); // Out of range write is dropped
    apb_xfer(1'b0, 16'd300, 16'h0000);
    apb_xfer(1'b0, 16'd44, 16'h0000);       // Alias of 300 stays untouched
    @(negedge clk) apb_req = '0;
    report_test("apb_load");

    soft_rst = 1'b1; // Restart fetch on the loaded program
    repeat (2) @(negedge clk);
    soft_rst    = 1'b0;
    fetch_check = 1'b1;
    repeat (SEQ_CYC - 4) @(negedge clk);
    report_test("sequential_fetch");

    for (int c = 0; c < STALL_CYC - 4; c++) @(negedge clk) stall = 1'($urandom_range(0, 1));
    stall = 1'b0;
    report_test("stall_hold");

    for (int n = 0; n < 8; n++) begin
      @(negedge clk);
      resolve = '{valid: 1'b1, branch: 1'b0, index: '0, taken: 1'b0, target: '0,
                  mispredict: 1'b1, redirect_pc: 16'($urandom)};
      stall   = 1'($urandom_range(0, 1)); // Redirect must win over stall
      @(negedge clk) {resolve, stall} = '0;
      repeat (3) @(negedge clk);
    end
    report_test("mispredict_redirect");

    idx = 4'($urandom);
    tgt = 16'($urandom);
    for (int k = 0; k < 2; k++) begin
      @(negedge clk);
      resolve = '{valid: 1'b1, branch: 1'b1, index: idx, taken: 1'b1, target: tgt,
                  mispredict: 1'b0, redirect_pc: '0};
    end
    @(negedge clk) resolve = '0;
    repeat (40) @(negedge clk); // Index comes round within 16 fetches
    // Counter walks 11 to 10 to 01 with fetches between the steps
    for (int k = 0; k < 2; k++) begin
      @(negedge clk);
      resolve = '{valid: 1'b1, branch: 1'b1, index: idx, taken: 1'b0, target: '0,
                  mispredict: 1'b0, redirect_pc: '0};
      @(negedge clk) resolve = '0;
      repeat (24) @(negedge clk);
    end
    report_test("predictor_training");

    $display("Summary: %0d tests passed, %0d tests failed, %0d check failures",
             tests_passed, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/inst_mem.sv
rtl/branch_predictor.sv
rtl/next_pc_select.sv
rtl/if_id_pipe_reg.sv
rtl/fetch_frontend.sv
testbench/tb_clock.sv
testbench/tb_fetch_frontend.sv

// File: Bender.yml
package:
  name: fetch_frontend

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/fetch_pkg.sv
      - rtl/inst_mem.sv
      - rtl/branch_predictor.sv
      - rtl/next_pc_select.sv
      - rtl/if_id_pipe_reg.sv
      - rtl/fetch_frontend.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_fetch_frontend.sv
